/* source/omega_cfg.svh */
`ifndef OMEGA_CFG_SVH
`define OMEGA_CFG_SVH

// field is GF(2^8) with x^8+x^4+x^3+x^2+1
// only the low byte is kept, the x^8 term is implied
`define OMEGA_GF_POLY 8'h1d

// bits in one field element
`define OMEGA_GF_WIDTH 8

// rows and columns of the block matrix
`define OMEGA_DIM 4

// one block, 16 bytes, row 0 column 0 in the top byte
`define OMEGA_BLOCK_WIDTH 128

// coefficient rows, column 0 in the high byte
// each row holds the powers 0..3 of one element: 1, 2, 6 and 8
`define OMEGA_COEF_ROW0 32'h01_01_01_01

`define OMEGA_COEF_ROW1 32'h01_02_04_08

`define OMEGA_COEF_ROW2 32'h01_06_14_78

// 8^3 wraps past x^8 and reduces to 3a
`define OMEGA_COEF_ROW3 32'h01_08_40_3a

`endif

/* source/gf_pkg.sv */
`include "omega_cfg.svh"

package gf_pkg;

    // one element of GF(2^8)
    typedef logic [`OMEGA_GF_WIDTH-1:0] gf_elem_t;

    // four coefficients of one matrix row
    // index DIM-1 is column 0, so the word reads left to right
    typedef gf_elem_t [`OMEGA_DIM-1:0] gf_coef_row_t;

    // coefficient for column k of a row
    function automatic gf_elem_t coef_at(
        input gf_coef_row_t row,
        input int unsigned  k
    );
        gf_elem_t c;
        c = row[`OMEGA_DIM-1-k];
        return c;
    endfunction

endpackage

/* source/omega_pkg.sv */
`include "omega_cfg.svh"

package omega_pkg;

    import gf_pkg::*;

    // one matrix column, row 0 in the high byte
    typedef struct packed {
        gf_elem_t row0;
        gf_elem_t row1;
        gf_elem_t row2;
        gf_elem_t row3;
    } omega_column_t;

    // one matrix row, column 0 in the high byte
    typedef struct packed {
        gf_elem_t col0;
        gf_elem_t col1;
        gf_elem_t col2;
        gf_elem_t col3;
    } omega_row_t;

    // full block, rows in bus order
    typedef struct packed {
        omega_row_t row0;
        omega_row_t row1;
        omega_row_t row2;
        omega_row_t row3;
    } omega_matrix_t;

    // flat at the ports, byte matrix inside the transform
    typedef union packed {
        logic [`OMEGA_BLOCK_WIDTH-1:0] word;
        omega_matrix_t                 matrix;
    } omega_block_u;

endpackage

/* source/gf_mul.sv */
`timescale 1ns/1ps

`include "omega_cfg.svh"

module gf_mul
    import gf_pkg::*;
#(
    parameter gf_elem_t COEF = 8'h01
) (
    input  gf_elem_t elem,
    output gf_elem_t product
);

    // running product of the shift-and-add loop
    gf_elem_t acc;

    // multiply by x, then fold x^8 back in
    function automatic gf_elem_t xtime(input gf_elem_t a);
        gf_elem_t shifted;
        shifted = {a[`OMEGA_GF_WIDTH-2:0], 1'b0};
        if (a[`OMEGA_GF_WIDTH-1]) begin
            shifted = shifted ^ `OMEGA_GF_POLY;
        end
        return shifted;
    endfunction

    // horner form, msb of the coefficient first
    always_comb begin
        acc = '0;
        for (int i = `OMEGA_GF_WIDTH-1; i >= 0; i--) begin
            acc = xtime(acc);
            if (COEF[i]) begin
                acc = acc ^ elem;
            end
        end
    end

    // COEF is fixed, so the loop folds into a plain xor network
    assign product = acc;

endmodule

/* source/gf_dot4.sv */
`timescale 1ns/1ps

`include "omega_cfg.svh"

module gf_dot4
    import gf_pkg::*;
    import omega_pkg::*;
#(
    parameter gf_coef_row_t COEF_ROW = `OMEGA_COEF_ROW0
) (
    input  omega_column_t column,
    output gf_elem_t      sum
);

    // column bytes by row index
    gf_elem_t col_elem [`OMEGA_DIM];

    // one product per coefficient
    gf_elem_t prod [`OMEGA_DIM];

    gf_elem_t acc;

    assign col_elem[0] = column.row0;
    assign col_elem[1] = column.row1;
    assign col_elem[2] = column.row2;
    assign col_elem[3] = column.row3;

    // coefficient k pairs with row k of the column
    for (genvar k = 0; k < `OMEGA_DIM; k++) begin : g_term
        gf_mul #(
            .COEF (coef_at(COEF_ROW, k))
        ) u_mul (
            .elem    (col_elem[k]),
            .product (prod[k])
        );
    end

    // gf addition is xor
    always_comb begin
        acc = '0;
        for (int k = 0; k < `OMEGA_DIM; k++) begin
            acc = acc ^ prod[k];
        end
    end

    assign sum = acc;

endmodule

/* source/column_mix.sv */
`timescale 1ns/1ps

`include "omega_cfg.svh"

module column_mix
    import gf_pkg::*;
    import omega_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          load,
    input  omega_column_t column_in,
    output omega_column_t column_out
);

    // one coefficient row per output row
    localparam gf_coef_row_t COEF [`OMEGA_DIM] = '{
        `OMEGA_COEF_ROW0,
        `OMEGA_COEF_ROW1,
        `OMEGA_COEF_ROW2,
        `OMEGA_COEF_ROW3
    };

    // combinational result, one byte per row
    gf_elem_t mix [`OMEGA_DIM];

    omega_column_t mix_col;

    omega_column_t col_q;

    for (genvar r = 0; r < `OMEGA_DIM; r++) begin : g_row
        gf_dot4 #(
            .COEF_ROW (COEF[r])
        ) u_dot (
            .column (column_in),
            .sum    (mix[r])
        );
    end

    always_comb begin
        mix_col.row0 = mix[0];
        mix_col.row1 = mix[1];
        mix_col.row2 = mix[2];
        mix_col.row3 = mix[3];
    end

    // result holds between loads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q <= '0;
        end else if (load) begin
            col_q <= mix_col;
        end
    end

    assign column_out = col_q;

endmodule

/* source/omega_transform.sv */
`timescale 1ns/1ps

`include "omega_cfg.svh"

module omega_transform
    import gf_pkg::*;
    import omega_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [`OMEGA_BLOCK_WIDTH-1:0] data_in,
    output logic                          out_valid,
    output logic [`OMEGA_BLOCK_WIDTH-1:0] data_out
);

    // captured input block
    omega_block_u block_q;

    // rebuilt output block
    omega_block_u block_out;

    // stage 1 valid, lines up with block_q
    logic valid_s1;

    // stage 2 valid, lines up with the column registers
    logic valid_s2;

    omega_column_t col_in  [`OMEGA_DIM];
    omega_column_t col_out [`OMEGA_DIM];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            block_q.word <= data_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= in_valid;
            valid_s2 <= valid_s1;
        end
    end

    // column c takes byte c of every row
    always_comb begin
        col_in[0] = {block_q.matrix.row0.col0, block_q.matrix.row1.col0,
                     block_q.matrix.row2.col0, block_q.matrix.row3.col0};
        col_in[1] = {block_q.matrix.row0.col1, block_q.matrix.row1.col1,
                     block_q.matrix.row2.col1, block_q.matrix.row3.col1};
        col_in[2] = {block_q.matrix.row0.col2, block_q.matrix.row1.col2,
                     block_q.matrix.row2.col2, block_q.matrix.row3.col2};
        col_in[3] = {block_q.matrix.row0.col3, block_q.matrix.row1.col3,
                     block_q.matrix.row2.col3, block_q.matrix.row3.col3};
    end

    for (genvar c = 0; c < `OMEGA_DIM; c++) begin : g_col
        column_mix u_mix (
            .clk        (clk),
            .rst_n      (rst_n),
            .load       (valid_s1),
            .column_in  (col_in[c]),
            .column_out (col_out[c])
        );
    end

    // back to row-major order for the bus
    always_comb begin
        block_out.matrix.row0 = {col_out[0].row0, col_out[1].row0,
                                 col_out[2].row0, col_out[3].row0};
        block_out.matrix.row1 = {col_out[0].row1, col_out[1].row1,
                                 col_out[2].row1, col_out[3].row1};
        block_out.matrix.row2 = {col_out[0].row2, col_out[1].row2,
                                 col_out[2].row2, col_out[3].row2};
        block_out.matrix.row3 = {col_out[0].row3, col_out[1].row3,
                                 col_out[2].row3, col_out[3].row3};
    end

    assign data_out  = block_out.word;
    assign out_valid = valid_s2;

endmodule

/* testbench/omega_checker.sv */
`timescale 1ns/1ps

`include "omega_cfg.svh"

module omega_checker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [`OMEGA_BLOCK_WIDTH-1:0] data_in,
    input  logic                          out_valid,
    input  logic [`OMEGA_BLOCK_WIDTH-1:0] data_out,
    output int                            value_errors,
    output int                            strobe_errors,
    output int                            in_count,
    output int                            out_count,
    output int                            pending
);

    // one block in flight with the cycle it was sampled on
    typedef struct packed {
        logic [`OMEGA_BLOCK_WIDTH-1:0] block;
        logic [31:0]                   cycle;
    } inflight_t;

    // coefficient matrix, row 0 column 0 in the top byte
    localparam logic [127:0] COEF_TABLE = 128'h01010101_01020408_01061478_0108403a;

    inflight_t   fifo [$];
    logic [31:0] cycle;

    function automatic logic [7:0] byte_at(input logic [127:0] blk, input int r, input int c);
        return blk[127 - 8 * (4 * r + c) -: 8];
    endfunction

    function automatic logic [127:0] with_byte(
        input logic [127:0] blk,
        input int           r,
        input int           c,
        input logic [7:0]   v
    );
        logic [127:0] res;
        res = blk;
        res[127 - 8 * (4 * r + c) -: 8] = v;
        return res;
    endfunction

    // shift-and-add, lsb of b first, reducing by the field polynomial
    function automatic logic [7:0] gf_times(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] x;
        logic [7:0] y;
        acc = 8'h00;
        x = a;
        y = b;
        for (int i = 0; i < 8; i++) begin
            if (y[0]) begin
                acc = acc ^ x;
            end
            y = y >> 1;
            if (x[7]) begin
                x = {x[6:0], 1'b0} ^ `OMEGA_GF_POLY;
            end else begin
                x = {x[6:0], 1'b0};
            end
        end
        return acc;
    endfunction

    function automatic logic [127:0] model_block(input logic [127:0] blk);
        logic [127:0] res;
        logic [7:0]   s;
        res = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                s = 8'h00;
                for (int k = 0; k < 4; k++) begin
                    s = s ^ gf_times(byte_at(COEF_TABLE, r, k), byte_at(blk, k, c));
                end
                res = with_byte(res, r, c, s);
            end
        end
        return res;
    endfunction

    // true when the block is a single 01 byte and zero elsewhere
    function automatic bit single_one(input logic [127:0] blk, output int k, output int c);
        int hits;
        hits = 0;
        k = 0;
        c = 0;
        for (int r = 0; r < 4; r++) begin
            for (int cc = 0; cc < 4; cc++) begin
                if (byte_at(blk, r, cc) != 8'h00) begin
                    hits++;
                    k = r;
                    c = cc;
                end
            end
        end
        return (hits == 1) && (byte_at(blk, k, c) == 8'h01);
    endfunction

    task automatic compare_block(input logic [127:0] blk);
        logic [127:0] expected;
        logic [127:0] unit_exp;
        logic [31:0]  row_sum;
        int           k;
        int           c;
        expected = model_block(blk);
        if (data_out !== expected) begin
            value_errors++;
            $display("** Error @ %0t: block mismatch, expected %h received %h",
                     $time, expected, data_out);
        end
        // row 0 of the matrix is all ones, so it is the xor of the input rows
        row_sum = blk[127:96] ^ blk[95:64] ^ blk[63:32] ^ blk[31:0];
        if (data_out[127:96] !== row_sum) begin
            value_errors++;
            $display("** Error @ %0t: output row 0, expected %h received %h",
                     $time, row_sum, data_out[127:96]);
        end
        if (single_one(blk, k, c)) begin
            unit_exp = '0;
            for (int r = 0; r < 4; r++) begin
                unit_exp = with_byte(unit_exp, r, c, byte_at(COEF_TABLE, r, k));
            end
            if (data_out !== unit_exp) begin
                value_errors++;
                $display("** Error @ %0t: unit byte at row %0d col %0d, expected %h received %h",
                         $time, k, c, unit_exp, data_out);
            end
        end
    endtask

    initial begin
        value_errors = 0;
        strobe_errors = 0;
        in_count = 0;
        out_count = 0;
        pending = 0;
        cycle = 0;
    end

    // blocks in flight are lost on reset
    always @(negedge rst_n) begin
        fifo.delete();
        pending = 0;
        in_count = 0;
        out_count = 0;
    end

    always @(posedge clk) begin : sample
        inflight_t head;
        inflight_t item;
        if (!rst_n) begin
            if (out_valid) begin
                strobe_errors++;
                $display("out_valid was high during reset at %0t", $time);
            end
        end else begin
            cycle = cycle + 1;
            // pop before push, the latency is never zero
            if (out_valid) begin
                out_count++;
                if (fifo.size() == 0) begin
                    strobe_errors++;
                    $display("out_valid rose at %0t with no block in flight", $time);
                end else begin
                    head = fifo.pop_front();
                    if (head.cycle + 2 != cycle) begin
                        strobe_errors++;
                        $display("block sent on cycle %0d came out on cycle %0d, not 2 later",
                                 head.cycle, cycle);
                    end
                    compare_block(head.block);
                end
            end
            if (in_valid) begin
                in_count++;
                item.block = data_in;
                item.cycle = cycle;
                fifo.push_back(item);
            end
            pending = fifo.size();
        end
    end

endmodule

/* testbench/omega_tb.sv */
`timescale 1ns/1ps

`include "omega_cfg.svh"

module omega_tb;

    localparam int DRAIN_LIMIT = 20;

    logic                          clk;
    logic                          rst_n;
    logic                          in_valid;
    logic [`OMEGA_BLOCK_WIDTH-1:0] data_in;
    logic                          out_valid;
    logic [`OMEGA_BLOCK_WIDTH-1:0] data_out;

    int value_errors;
    int strobe_errors;
    int in_count;
    int out_count;
    int pending;
    int timeout_errors;
    int count_errors;

    logic [31:0]                   rng_state;
    logic [`OMEGA_BLOCK_WIDTH-1:0] blk;
    logic [31:0]                   gap;

    omega_transform UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .data_in   (data_in),
        .out_valid (out_valid),
        .data_out  (data_out)
    );

    omega_checker u_check (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .data_in       (data_in),
        .out_valid     (out_valid),
        .data_out      (data_out),
        .value_errors  (value_errors),
        .strobe_errors (strobe_errors),
        .in_count      (in_count),
        .out_count     (out_count),
        .pending       (pending)
    );

    always #50 clk = ~clk;

    // 32-bit xorshift step
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng_state = next_random(rng_state);
        v = rng_state;
    endtask

    task automatic make_random_block(output logic [`OMEGA_BLOCK_WIDTH-1:0] b);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            draw(w);
            b[127 - 32 * i -: 32] = w;
        end
    endtask

    task automatic send_block(input logic [`OMEGA_BLOCK_WIDTH-1:0] b);
        @(negedge clk);
        in_valid = 1'b1;
        data_in = b;
    endtask

    task automatic go_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        while (pending != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            timeout_errors++;
            $display("timed out with %0d blocks still in flight after %s", pending, what);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        in_valid = 1'b0;
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
        end
        rst_n = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        data_in = '0;
        rng_state = 32'd51;
        timeout_errors = 0;
        count_errors = 0;

        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
        end
        rst_n = 1'b1;
        // out_valid must stay low until the first block
        go_idle(4);

        // zero block, then a single 01 at every position
        send_block('0);
        for (int k = 0; k < 4; k++) begin
            for (int c = 0; c < 4; c++) begin
                blk = '0;
                blk[127 - 8 * (4 * k + c) -: 8] = 8'h01;
                send_block(blk);
            end
        end
        wait_drain("directed blocks");

        // back to back
        for (int i = 0; i < 40; i++) begin
            make_random_block(blk);
            send_block(blk);
        end
        wait_drain("back-to-back blocks");
        if (in_count != out_count) begin
            count_errors++;
            $display("%0d blocks went in but %0d came out", in_count, out_count);
        end

        // random gaps of up to 3 idle cycles
        for (int i = 0; i < 60; i++) begin
            make_random_block(blk);
            send_block(blk);
            draw(gap);
            go_idle(gap % 4);
        end
        wait_drain("blocks with gaps");

        // reset with blocks in flight, none of them may come out
        for (int i = 0; i < 3; i++) begin
            make_random_block(blk);
            send_block(blk);
        end
        apply_reset();
        go_idle(6);

        // recovery after the reset
        for (int i = 0; i < 20; i++) begin
            make_random_block(blk);
            send_block(blk);
        end
        wait_drain("blocks after reset");
        if (in_count != out_count) begin
            count_errors++;
            $display("%0d blocks went in after reset but %0d came out", in_count, out_count);
        end

        $display("errors: value %0d, strobe %0d, timeout %0d, count %0d",
                 value_errors, strobe_errors, timeout_errors, count_errors);
        if (value_errors + strobe_errors + timeout_errors + count_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+source
source/gf_pkg.sv
source/omega_pkg.sv
source/gf_mul.sv
source/gf_dot4.sv
source/column_mix.sv
source/omega_transform.sv
testbench/omega_checker.sv
testbench/omega_tb.sv

/* Bender.yml */
package:
  name: omega_transform

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/gf_pkg.sv
      - source/omega_pkg.sv
      - source/gf_mul.sv
      - source/gf_dot4.sv
      - source/column_mix.sv
      - source/omega_transform.sv

  - target: test
    include_dirs:
      - source
    files:
      - testbench/omega_checker.sv
      - testbench/omega_tb.sv
